// File: decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Bus widths
`define DATA_W   8
`define ADDR_W   16
`define STATUS_W 8

// Status byte bit positions
`define FLAG_C 0
`define FLAG_Z 1
`define FLAG_V 6
`define FLAG_N 7

`endif

// File: isa_pkg.sv
`include "decode_config.svh"

package isa_pkg;

    // Standard 6502 encodings of the supported opcodes
    typedef enum logic [7:0] {
        op_nop     = 8'hEA,
        op_sec     = 8'h38,
        op_clc     = 8'h18,
        op_clv     = 8'hB8,
        op_tax     = 8'hAA,
        op_tay     = 8'hA8,
        op_txa     = 8'h8A,
        op_tya     = 8'h98,
        op_inx     = 8'hE8,
        op_iny     = 8'hC8,
        op_dex     = 8'hCA,
        op_dey     = 8'h88,
        op_lda_imm = 8'hA9,
        op_ldx_imm = 8'hA2,
        op_ldy_imm = 8'hA0,
        op_asl_a   = 8'h0A,
        op_lsr_a   = 8'h4A,
        op_rol_a   = 8'h2A,
        op_ror_a   = 8'h6A,
        op_asl_zpg = 8'h06,
        op_asl_abs = 8'h0E,
        op_lsr_zpg = 8'h46,
        op_lsr_abs = 8'h4E,
        op_rol_zpg = 8'h26,
        op_rol_abs = 8'h2E,
        op_ror_zpg = 8'h66,
        op_ror_abs = 8'h6E,
        op_inc_zpg = 8'hE6,
        op_inc_abs = 8'hEE,
        op_dec_zpg = 8'hC6,
        op_dec_abs = 8'hCE,
        op_and_zpg = 8'h25,
        op_and_abs = 8'h2D,
        op_cmp_zpg = 8'hC5,
        op_cmp_abs = 8'hCD,
        op_ora_zpg = 8'h05,
        op_eor_zpg = 8'h45,
        op_lda_zpg = 8'hA5,
        op_ldx_zpg = 8'hA6,
        op_ldy_zpg = 8'hA4,
        op_sta_zpg = 8'h85,
        op_stx_zpg = 8'h86,
        op_sty_zpg = 8'h84,
        op_jmp_abs = 8'h4C
    } opcode_e;

    typedef enum logic [2:0] {
        am_implied, am_immediate, am_accumulator, am_zero_page, am_absolute
    } addr_mode_e;

    typedef enum logic [4:0] {
        alu_nop, alu_asl, alu_lsr, alu_rol, alu_ror, alu_and, alu_or, alu_xor,
        alu_cmp, alu_inc, alu_dec, alu_flg, alu_tmx
    } alu_op_e;

    typedef enum logic [1:0] {reg_none, reg_a, reg_x, reg_y} reg_sel_e;

    // All-zero encoding is the NOP class
    typedef struct packed {
        addr_mode_e           addr_mode;
        alu_op_e              alu_op;
        reg_sel_e             dst_reg;
        reg_sel_e             src_reg;
        logic [`STATUS_W-1:0] flag_mask;
        logic                 is_store;
        logic                 is_rmw;     // Read-modify-write on memory
        logic                 is_jump;
        logic                 is_transfer;
        logic                 is_flag_set;
        logic                 flag_value;
    } instr_class_t;

endpackage

// File: ctrl_pkg.sv
`include "decode_config.svh"

package ctrl_pkg;

    typedef enum logic [3:0] {
        s_idle,
        s_opcode_read,
        s_zpg_adr_read,
        s_abs_lb,
        s_abs_hb,
        s_idl_data_write,
        s_alu_final,
        s_alu_tmx,
        s_dbuf_output,
        s_pc_load
    } decode_state_e;

    typedef enum logic [2:0] {
        reg_idle, reg_load_bus1, reg_store_bus1, reg_load_bus2, reg_store_bus2
    } reg_op_e;

    typedef enum logic [1:0] {buf_idle, buf_load, buf_store} buf_op_e;

    typedef enum logic [1:0] {pc_hold, pc_inc_one, pc_load} pc_op_e;

    typedef enum logic {sel_pc, sel_mem} addr_sel_e;

    typedef struct packed {
        logic [`ADDR_W-1:0] memory_address;
        addr_sel_e          address_select;
        logic               rw;            // 1 reads, 0 writes
        buf_op_e            data_buffer;
        buf_op_e            input_latch;
    } bus_ctrl_t;

    typedef struct packed {
        reg_op_e acc;
        reg_op_e x;
        reg_op_e y;
    } reg_ctrl_t;

    typedef struct packed {
        logic [`STATUS_W-1:0] write_mask;
        logic [`STATUS_W-1:0] value;
        logic                 psr_rw;      // 0 lets the ALU update flags
    } flag_ctrl_t;

endpackage

// File: opcode_classifier.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module opcode_classifier (
    input  logic [`DATA_W-1:0]    instruction,
    output isa_pkg::instr_class_t instr_class
);
    import isa_pkg::*;

    localparam logic [`STATUS_W-1:0] zn_mask = `STATUS_W'(1 << `FLAG_Z)
                                             | `STATUS_W'(1 << `FLAG_N);
    localparam logic [`STATUS_W-1:0] czn_mask = zn_mask | `STATUS_W'(1 << `FLAG_C);

    addr_mode_e           bit_mode;
    reg_sel_e             ld_st_reg;

    always_comb begin
        case (instruction[4:2])
            3'b001:  bit_mode = am_zero_page;
            3'b010:  bit_mode = am_accumulator;
            3'b011:  bit_mode = am_absolute;
            default: bit_mode = am_implied;
        endcase
        case (instruction[1:0])   // Register of the load/store family
            2'b00:   ld_st_reg = reg_y;
            2'b01:   ld_st_reg = reg_a;
            default: ld_st_reg = reg_x;
        endcase
    end

    always_comb begin
        instr_class = '0;   // NOP and unknown opcodes
        case (opcode_e'(instruction))
            op_sec, op_clc, op_clv: begin
                instr_class.is_flag_set = 1'b1;
                instr_class.flag_value = (instruction == op_sec);
                if (instruction == op_clv) begin
                    instr_class.flag_mask[`FLAG_V] = 1'b1;
                end else begin
                    instr_class.flag_mask[`FLAG_C] = 1'b1;
                end
            end
            op_tax, op_tay, op_txa, op_tya: begin
                instr_class.is_transfer = 1'b1;
                instr_class.src_reg = instruction[4] ? reg_y : reg_x;
                instr_class.dst_reg = reg_a;
                if (instruction[5]) begin   // TAX/TAY go the other way
                    instr_class.src_reg = reg_a;
                    instr_class.dst_reg = (instruction[1]) ? reg_x : reg_y;
                end
            end
            op_inx, op_dex, op_iny, op_dey: begin
                if (instruction == op_inx || instruction == op_iny) begin
                    instr_class.alu_op = alu_inc;
                end else begin
                    instr_class.alu_op = alu_dec;
                end
                if (instruction == op_inx || instruction == op_dex) begin
                    instr_class.src_reg = reg_x;
                end else begin
                    instr_class.src_reg = reg_y;
                end
                instr_class.dst_reg = instr_class.src_reg;
                instr_class.flag_mask = zn_mask;
            end
            op_lda_imm, op_ldx_imm, op_ldy_imm, op_lda_zpg, op_ldx_zpg, op_ldy_zpg: begin
                instr_class.addr_mode = (bit_mode == am_zero_page) ? am_zero_page : am_immediate;
                instr_class.alu_op = alu_flg;
                instr_class.dst_reg = ld_st_reg;
                instr_class.flag_mask = zn_mask;
            end
            op_sta_zpg, op_stx_zpg, op_sty_zpg: begin
                instr_class.addr_mode = bit_mode;
                instr_class.src_reg = ld_st_reg;
                instr_class.is_store = 1'b1;
            end
            op_asl_a, op_asl_zpg, op_asl_abs, op_rol_a, op_rol_zpg, op_rol_abs,
            op_lsr_a, op_lsr_zpg, op_lsr_abs, op_ror_a, op_ror_zpg, op_ror_abs: begin
                instr_class.addr_mode = bit_mode;
                case (instruction[6:5])
                    2'b00:   instr_class.alu_op = alu_asl;
                    2'b01:   instr_class.alu_op = alu_rol;
                    2'b10:   instr_class.alu_op = alu_lsr;
                    default: instr_class.alu_op = alu_ror;
                endcase
                instr_class.flag_mask = czn_mask;
                if (bit_mode == am_accumulator) begin
                    instr_class.src_reg = reg_a;
                    instr_class.dst_reg = reg_a;
                end else begin
                    instr_class.is_rmw = 1'b1;
                end
            end
            op_inc_zpg, op_inc_abs, op_dec_zpg, op_dec_abs: begin
                instr_class.addr_mode = bit_mode;
                instr_class.alu_op = (instruction[5]) ? alu_inc : alu_dec;
                instr_class.flag_mask = zn_mask;
                instr_class.is_rmw = 1'b1;
            end
            op_ora_zpg, op_and_zpg, op_and_abs, op_eor_zpg: begin
                instr_class.addr_mode = bit_mode;
                case (instruction[6:5])
                    2'b00:   instr_class.alu_op = alu_or;
                    2'b01:   instr_class.alu_op = alu_and;
                    default: instr_class.alu_op = alu_xor;
                endcase
                instr_class.src_reg = reg_a;
                instr_class.dst_reg = reg_a;
                instr_class.flag_mask = zn_mask;
            end
            op_cmp_zpg, op_cmp_abs: begin
                instr_class.addr_mode = bit_mode;
                instr_class.alu_op = alu_cmp;
                instr_class.src_reg = reg_a;   // Result only reaches the flags
                instr_class.flag_mask = czn_mask;
            end
            op_jmp_abs: begin
                instr_class.addr_mode = am_absolute;
                instr_class.is_jump = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: decode_sequencer.sv
`timescale 1ns/1ns

module decode_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_enable,
    input  isa_pkg::instr_class_t  instr_class,
    output ctrl_pkg::decode_state_e state,
    output isa_pkg::instr_class_t  cur_class
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    decode_state_e next_state;

    always_comb begin
        next_state = s_idle;
        case (state)
            s_idle: next_state = s_opcode_read;
            s_opcode_read: begin
                case (cur_class.addr_mode)
                    am_immediate:   next_state = s_idl_data_write;
                    am_accumulator: next_state = s_alu_final;
                    am_zero_page:   next_state = s_zpg_adr_read;
                    am_absolute:    next_state = s_abs_lb;
                    default: begin   // Implied; only INX/INY/DEX/DEY use the ALU
                        if (cur_class.alu_op != alu_nop) begin
                            next_state = s_alu_final;
                        end
                    end
                endcase
            end
            s_zpg_adr_read: next_state = s_idl_data_write;
            s_abs_lb: next_state = (cur_class.is_jump) ? s_pc_load : s_abs_hb;
            s_abs_hb: next_state = s_idl_data_write;
            s_idl_data_write: next_state = s_alu_final;
            s_alu_final: next_state = s_alu_tmx;
            s_alu_tmx: begin
                if (cur_class.is_store || cur_class.is_rmw) begin
                    next_state = s_dbuf_output;
                end
            end
            default: next_state = s_idle;   // dbuf_output and pc_load end here
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
            cur_class <= '0;
        end else if (clk_enable) begin
            state <= next_state;
            if (state == s_idle) begin
                cur_class <= instr_class;   // Opcode byte is on the bus now
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        state inside {s_idle, s_opcode_read, s_zpg_adr_read, s_abs_lb, s_abs_hb,
                      s_idl_data_write, s_alu_final, s_alu_tmx, s_dbuf_output, s_pc_load})
        else $error("decode state left its legal range");

endmodule

// File: operand_address_latch.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module operand_address_latch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clk_enable,
    input  logic [`DATA_W-1:0]      instruction,
    input  ctrl_pkg::decode_state_e state,
    output logic [`ADDR_W-1:0]      operand_address
);
    import ctrl_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            operand_address <= '0;
        end else if (clk_enable) begin
            if (state == s_opcode_read) begin
                // Low byte follows the opcode; zero page keeps high byte 0
                operand_address <= {{(`ADDR_W - `DATA_W){1'b0}}, instruction};
            end else if (state == s_abs_lb) begin
                operand_address[`ADDR_W-1 -: `DATA_W] <= instruction;
            end
        end
    end

endmodule

// File: control_word_gen.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module control_word_gen (
    input  ctrl_pkg::decode_state_e state,
    input  isa_pkg::instr_class_t   cur_class,
    input  logic [`ADDR_W-1:0]      operand_address,
    output ctrl_pkg::bus_ctrl_t     bus,
    output ctrl_pkg::reg_ctrl_t     regs,
    output ctrl_pkg::flag_ctrl_t    flags,
    output ctrl_pkg::pc_op_e        pc_enable,
    output isa_pkg::alu_op_e        alu_op
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic mem_operand;

    function automatic reg_ctrl_t drive_reg(reg_ctrl_t cur, reg_sel_e sel, reg_op_e op);
        reg_ctrl_t res;
        res = cur;
        case (sel)
            reg_a:   res.acc = op;
            reg_x:   res.x = op;
            reg_y:   res.y = op;
            default: ;
        endcase
        return res;
    endfunction

    assign mem_operand = cur_class.addr_mode inside {am_immediate, am_zero_page, am_absolute};

    always_comb begin
        bus = '{memory_address: '0, address_select: sel_pc, rw: 1'b1,
                data_buffer: buf_idle, input_latch: buf_idle};
        regs = '{acc: reg_idle, x: reg_idle, y: reg_idle};
        flags = '{write_mask: '0, value: '0, psr_rw: 1'b1};
        pc_enable = pc_hold;
        alu_op = alu_nop;
        case (state)
            s_opcode_read: begin
                pc_enable = pc_inc_one;
                if (cur_class.is_flag_set) begin
                    flags.write_mask = cur_class.flag_mask;
                    flags.value = (cur_class.flag_value) ? cur_class.flag_mask : '0;
                    flags.value[`FLAG_N] = 1'b1;
                end
                if (cur_class.is_transfer) begin
                    regs = drive_reg(regs, cur_class.dst_reg, reg_load_bus1);
                    regs = drive_reg(regs, cur_class.src_reg, reg_store_bus1);
                end
            end
            s_zpg_adr_read, s_abs_hb: begin
                pc_enable = pc_inc_one;
                bus.address_select = sel_mem;
                bus.memory_address = operand_address;
            end
            s_abs_lb: pc_enable = pc_inc_one;
            s_idl_data_write: bus.input_latch = buf_load;
            s_alu_final: begin
                flags.psr_rw = 1'b0;
                flags.write_mask = cur_class.flag_mask;
                alu_op = cur_class.alu_op;
                if (!cur_class.is_store) begin
                    if (mem_operand) begin
                        bus.input_latch = buf_store;
                        regs = drive_reg(regs, cur_class.src_reg, reg_store_bus2);   // AND/CMP partner
                    end else begin
                        regs = drive_reg(regs, cur_class.src_reg, reg_store_bus1);
                    end
                end
            end
            s_alu_tmx: begin
                if (cur_class.is_store) begin
                    regs = drive_reg(regs, cur_class.src_reg, reg_store_bus2);
                    bus.data_buffer = buf_load;
                end else if (cur_class.is_rmw) begin
                    bus.data_buffer = buf_load;
                    alu_op = alu_tmx;
                end else if (cur_class.dst_reg != reg_none) begin
                    regs = drive_reg(regs, cur_class.dst_reg, reg_load_bus2);
                    alu_op = alu_tmx;
                end
            end
            s_dbuf_output: begin
                bus.data_buffer = buf_store;
                bus.rw = 1'b0;
                bus.address_select = sel_mem;
                bus.memory_address = operand_address;
            end
            s_pc_load: begin
                pc_enable = pc_load;
                bus.memory_address = operand_address;   // Jump target
            end
            default: ;
        endcase
    end

    always_comb begin
        assert #0 (bus.rw || bus.address_select == sel_mem)
            else $error("memory write issued without the operand address");
    end

endmodule

// File: instruction_decode.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module instruction_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_enable,
    input  logic [`DATA_W-1:0]   instruction,
    output ctrl_pkg::bus_ctrl_t  bus,
    output ctrl_pkg::reg_ctrl_t  regs,
    output ctrl_pkg::flag_ctrl_t flags,
    output ctrl_pkg::pc_op_e     pc_enable,
    output isa_pkg::alu_op_e     alu_op
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    instr_class_t       instr_class;
    instr_class_t       cur_class;
    decode_state_e      state;
    logic [`ADDR_W-1:0] operand_address;

    opcode_classifier u_classifier (
        .instruction (instruction),
        .instr_class (instr_class)
    );

    decode_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_enable  (clk_enable),
        .instr_class (instr_class),
        .state       (state),
        .cur_class   (cur_class)
    );

    operand_address_latch u_latch (
        .clk             (clk),
        .rst_n           (rst_n),
        .clk_enable      (clk_enable),
        .instruction     (instruction),
        .state           (state),
        .operand_address (operand_address)
    );

    control_word_gen u_ctrl (
        .state           (state),
        .cur_class       (cur_class),
        .operand_address (operand_address),
        .bus             (bus),
        .regs            (regs),
        .flags           (flags),
        .pc_enable       (pc_enable),
        .alu_op          (alu_op)
    );

endmodule

// File: tb_decode_tests.svh
task automatic fetch_expect();
    clear_expect();
    want_pc = pc_inc_one;
endtask

task automatic alu_final_expect(input alu_op_e op, input logic [`STATUS_W-1:0] mask);
    clear_expect();
    want_flags.psr_rw = 1'b0;
    want_flags.write_mask = mask;
    want_alu = op;
endtask

task automatic write_back_expect(input logic [`ADDR_W-1:0] addr);
    clear_expect();
    want_bus.data_buffer = buf_store;
    want_bus.rw = 1'b0;
    want_bus.address_select = sel_mem;
    want_bus.memory_address = addr;
endtask

task automatic reset_and_nop();
    logic [`DATA_W-1:0] opcodes [3] = '{8'hEA, 8'hEA, 8'hFF};   // 0xFF is not decoded
    for (int i = 0; i < 3; i++) begin
        clear_expect();
        advance(opcodes[i]);
        fetch_expect();
        advance(rand_byte());
    end
    report_test("reset values and NOP");
endtask

task automatic flag_set_clear();
    logic [`DATA_W-1:0] opcodes [3] = '{8'h38, 8'h18, 8'hB8};   // SEC, CLC, CLV
    int                 bit_pos [3] = '{`FLAG_C, `FLAG_C, `FLAG_V};
    logic               set_val [3] = '{1'b1, 1'b0, 1'b0};
    for (int i = 0; i < 3; i++) begin
        clear_expect();
        advance(opcodes[i]);
        fetch_expect();
        want_flags.write_mask = flag_bit(bit_pos[i]);
        want_flags.value = (set_val[i] ? flag_bit(bit_pos[i]) : '0) | flag_bit(`FLAG_N);
        advance(rand_byte());
    end
    report_test("SEC CLC CLV");
endtask

task automatic register_transfers();
    logic [`DATA_W-1:0] opcodes [4] = '{8'hAA, 8'hA8, 8'h8A, 8'h98};   // TAX TAY TXA TYA
    reg_ctrl_t          moves [4] = '{'{reg_store_bus1, reg_load_bus1, reg_idle},
                                      '{reg_store_bus1, reg_idle, reg_load_bus1},
                                      '{reg_load_bus1, reg_store_bus1, reg_idle},
                                      '{reg_load_bus1, reg_idle, reg_store_bus1}};
    for (int i = 0; i < 4; i++) begin
        clear_expect();
        advance(opcodes[i]);
        fetch_expect();
        want_regs = moves[i];
        advance(rand_byte());
    end
    report_test("register transfers");
endtask

task automatic load_then_shift();
    clear_expect();
    advance(8'hA9);   // LDA #imm
    fetch_expect();
    advance(8'h5A);
    clear_expect();
    want_bus.input_latch = buf_load;
    advance(rand_byte());
    alu_final_expect(alu_flg, flag_bit(`FLAG_Z) | flag_bit(`FLAG_N));
    want_bus.input_latch = buf_store;
    advance(rand_byte());
    clear_expect();
    want_regs.acc = reg_load_bus2;
    want_alu = alu_tmx;
    advance(rand_byte());
    clear_expect();
    advance(8'h0A);   // ASL A
    fetch_expect();
    advance(rand_byte());
    alu_final_expect(alu_asl, flag_bit(`FLAG_C) | flag_bit(`FLAG_Z) | flag_bit(`FLAG_N));
    want_regs.acc = reg_store_bus1;
    advance(rand_byte());
    clear_expect();
    want_regs.acc = reg_load_bus2;
    want_alu = alu_tmx;
    advance(rand_byte());
    report_test("LDA immediate then ASL A");
endtask

task automatic store_and_rmw();
    clear_expect();
    advance(8'h86);   // STX $42
    fetch_expect();
    advance(8'h42);
    fetch_expect();
    want_bus.address_select = sel_mem;
    want_bus.memory_address = 16'h0042;
    advance(rand_byte());
    clear_expect();
    want_bus.input_latch = buf_load;
    advance(rand_byte());
    alu_final_expect(alu_nop, '0);
    advance(rand_byte());
    clear_expect();
    want_regs.x = reg_store_bus2;
    want_bus.data_buffer = buf_load;
    advance(rand_byte());
    write_back_expect(16'h0042);
    advance(rand_byte());
    clear_expect();
    advance(8'hEE);   // INC $1234
    fetch_expect();
    advance(8'h34);
    fetch_expect();
    advance(8'h12);
    fetch_expect();
    want_bus.address_select = sel_mem;
    want_bus.memory_address = 16'h1234;
    advance(rand_byte());
    clear_expect();
    want_bus.input_latch = buf_load;
    advance(rand_byte());
    alu_final_expect(alu_inc, flag_bit(`FLAG_Z) | flag_bit(`FLAG_N));
    want_bus.input_latch = buf_store;
    advance(rand_byte());
    clear_expect();
    want_bus.data_buffer = buf_load;
    want_alu = alu_tmx;
    advance(rand_byte());
    write_back_expect(16'h1234);
    advance(rand_byte());
    report_test("STX zero page and INC absolute");
endtask

task automatic jump_with_stall();
    clear_expect();
    advance(8'h4C);   // JMP $BEEF
    fetch_expect();
    advance(8'hEF);
    fetch_expect();
    clk_enable = 1'b0;   // Hold in abs_lb while the bus carries junk
    repeat (5) advance(rand_byte());
    clk_enable = 1'b1;
    advance(8'hBE);
    clear_expect();
    want_pc = pc_load;
    want_bus.memory_address = 16'hBEEF;
    advance(rand_byte());
    clear_expect();
    advance(8'hEA);
    report_test("JMP absolute with stall");
endtask

// File: tb_instruction_decode.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module tb_instruction_decode;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int CLK_HALF   = 50;
    localparam int MAX_CYCLES = 400;   // Several times the length of the directed run

    logic               clk;
    logic               rst_n;
    logic               clk_enable;
    logic [`DATA_W-1:0] instruction;
    bus_ctrl_t          bus;
    reg_ctrl_t          regs;
    flag_ctrl_t         flags;
    pc_op_e             pc_enable;
    alu_op_e            alu_op;

    bus_ctrl_t  want_bus;
    reg_ctrl_t  want_regs;
    flag_ctrl_t want_flags;
    pc_op_e     want_pc;
    alu_op_e    want_alu;

    int check_count       = 0;
    int error_count       = 0;
    int test_count        = 0;
    int failed_tests      = 0;
    int test_start_errors = 0;
    int cycle_count       = 0;

    instruction_decode dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_enable  (clk_enable),
        .instruction (instruction),
        .bus         (bus),
        .regs        (regs),
        .flags       (flags),
        .pc_enable   (pc_enable),
        .alu_op      (alu_op)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [`DATA_W-1:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[`DATA_W-1:0];
    endfunction

    function automatic logic [`STATUS_W-1:0] flag_bit(input int pos);
        logic [`STATUS_W-1:0] m;
        m = '0;
        m[pos] = 1'b1;
        return m;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        check_count++;
        assert (got === want)
            else begin
                error_count++;
                $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
            end
    endtask

    // Idle outputs, as seen in s_idle
    task automatic clear_expect();
        want_bus = '{memory_address: '0, address_select: sel_pc, rw: 1'b1,
                     data_buffer: buf_idle, input_latch: buf_idle};
        want_regs = '{acc: reg_idle, x: reg_idle, y: reg_idle};
        want_flags = '{write_mask: '0, value: '0, psr_rw: 1'b1};
        want_pc = pc_hold;
        want_alu = alu_nop;
    endtask

    // Called 10 ns after a rising edge; outputs are settled by then
    task automatic advance(input logic [`DATA_W-1:0] data);
        instruction = data;
        compare_value("bus", bus, want_bus);
        compare_value("regs", regs, want_regs);
        compare_value("flags", flags, want_flags);
        compare_value("pc_enable", pc_enable, want_pc);
        compare_value("alu_op", alu_op, want_alu);
        @(posedge clk);
        #10;
    endtask

    task automatic report_test(input string name);
        int new_errors;
        new_errors = error_count - test_start_errors;
        test_count++;
        if (new_errors != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d errors", test_count, name, new_errors);
        test_start_errors = error_count;
    endtask

    `include "tb_decode_tests.svh"

    initial begin
        void'($urandom(32'hb1b7));
        rst_n = 1'b0;
        clk_enable = 1'b1;
        instruction = '0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        reset_and_nop();
        flag_set_clear();
        register_transfers();
        load_then_shift();
        store_and_rmw();
        jump_with_stall();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: instruction_decode.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
opcode_classifier.sv
decode_sequencer.sv
operand_address_latch.sv
control_word_gen.sv
instruction_decode.sv
tb_instruction_decode.sv

// File: Bender.yml
package:
  name: instruction_decode

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - ctrl_pkg.sv
      - opcode_classifier.sv
      - decode_sequencer.sv
      - operand_address_latch.sv
      - control_word_gen.sv
      - instruction_decode.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_instruction_decode.sv
